// File: src/rv_settings.svh
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

`define XLEN            64
`define INST_LEN        32

// major opcodes used by this stage.
`define OP_LOAD         7'b0000011
`define OP_STORE        7'b0100011
`define OP_SYSTEM       7'b1110011

// machine mode csr addresses.
`define CSR_MTVEC       12'h305
`define CSR_MSCRATCH    12'h340
`define CSR_MEPC        12'h341
`define CSR_MCAUSE      12'h342

`define MCAUSE_ECALL    64'd11

`endif

// File: src/rv_pkg.sv
`include "rv_settings.svh"

package rv_pkg;

    // load/store view, bits 11:7 carry imm[4:0] on a store.
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } mem_view_t;

    // system view, rs1 doubles as zimm.
    typedef struct packed {
        logic [11:0] csr;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } csr_view_t;

    typedef union packed {
        mem_view_t mem;
        csr_view_t csr;
    } instr_u;

    // encoding follows funct3, bit 2 selects zero extension.
    typedef enum logic [2:0] {
        MEM_B  = 3'b000,
        MEM_H  = 3'b001,
        MEM_W  = 3'b010,
        MEM_D  = 3'b011,
        MEM_BU = 3'b100,
        MEM_HU = 3'b101,
        MEM_WU = 3'b110,
        MEM_DU = 3'b111
    } mem_op_e;

    typedef struct packed {
        logic             rd_en;
        logic             wr_en;
        mem_op_e          op;
        logic [`XLEN-1:0] wr_data;
    } ls_req_t;

    typedef struct packed {
        logic [`XLEN-1:0]   addr;
        logic               rd_en;
        logic               wr_en;
        logic [`XLEN-1:0]   wr_data;
        logic [`XLEN/8-1:0] wr_mask;
        logic [2:0]         wr_size;
        logic [2:0]         rd_size;
    } sram_req_t;

endpackage

// File: src/ls_ctr.sv
`timescale 1ns/10ps
`include "rv_settings.svh"

module ls_ctr (
    input  rv_pkg::instr_u   instr_i,
    input  rv_pkg::instr_u   instr_last_i,
    input  logic [`XLEN-1:0] rs2_i,
    input  logic [`XLEN-1:0] wb_data_i,
    output rv_pkg::ls_req_t  req_o
);

    logic       is_load;
    logic       is_store;
    logic       last_is_store;
    logic [4:0] last_rd;
    logic [4:0] store_rs2;
    logic       fwd;

    assign is_load  = (instr_i.mem.opcode == `OP_LOAD);
    assign is_store = (instr_i.mem.opcode == `OP_STORE);

    // a store ahead of us has no rd, its bits 11:7 are immediate.
    assign last_is_store = (instr_last_i.mem.opcode == `OP_STORE);
    assign last_rd       = instr_last_i.mem.rd;
    assign store_rs2     = instr_i.mem.rs2;

    // x0 never holds a result worth forwarding.
    assign fwd = !last_is_store
              && (last_rd != 5'd0)
              && (last_rd == store_rs2);

    always_comb begin
        req_o.rd_en = is_load;
        req_o.wr_en = is_store;
        req_o.op    = rv_pkg::mem_op_e'(instr_i.mem.funct3);
        if (fwd) begin
            req_o.wr_data = wb_data_i;
        end else begin
            req_o.wr_data = rs2_i;
        end
    end

endmodule

// File: src/lsu.sv
`timescale 1ns/10ps
`include "rv_settings.svh"

module lsu (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                stall_n_i,
    input  logic [`XLEN-1:0]    addr_i,
    input  rv_pkg::ls_req_t     req_i,
    input  logic                rd_valid_i,
    input  logic                wr_ok_i,
    input  logic [`XLEN-1:0]    rd_data_i,
    output rv_pkg::sram_req_t   sram_req_o,
    output logic [`XLEN-1:0]    ls_res_o,
    output logic                ls_not_ok_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT,
        ST_DONE
    } state_e;

    state_e             state_q;
    state_e             state_d;
    logic               mem_req;
    logic               issue;
    logic               resp;
    logic               rd_en_q;
    logic               wr_en_q;
    logic [1:0]         size;
    logic [`XLEN/8-1:0] size_mask;
    logic [`XLEN-1:0]   addr_q;
    logic [`XLEN-1:0]   wr_data_q;
    logic [`XLEN/8-1:0] wr_mask_q;
    rv_pkg::mem_op_e    op_q;
    logic [`XLEN-1:0]   rd_shifted;
    logic [`XLEN-1:0]   rd_ext;

    assign mem_req = req_i.rd_en | req_i.wr_en;
    assign resp    = rd_valid_i | wr_ok_i;
    assign issue   = (state_q == ST_IDLE) && mem_req && stall_n_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (issue) begin
                    state_d = ST_WAIT;
                end
            end
            // the sram does not hold its answer, so it is taken even under stall.
            ST_WAIT: begin
                if (resp) begin
                    state_d = ST_DONE;
                end
            end
            // same instruction is still at the input until upstream moves on.
            ST_DONE: begin
                if (stall_n_i) begin
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
            rd_en_q <= 1'b0;
            wr_en_q <= 1'b0;
        end else begin
            state_q <= state_d;
            rd_en_q <= issue & req_i.rd_en;
            wr_en_q <= issue & req_i.wr_en;
        end
    end

    // log2 of the access size in bytes.
    assign size = req_i.op[1:0];

    always_comb begin
        case (size)
            2'd0:    size_mask = 8'h01;
            2'd1:    size_mask = 8'h03;
            2'd2:    size_mask = 8'h0f;
            default: size_mask = 8'hff;
        endcase
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            addr_q    <= addr_i;
            wr_data_q <= req_i.wr_data << {addr_i[2:0], 3'b000};
            wr_mask_q <= req_i.wr_en ? (size_mask << addr_i[2:0]) : '0;
            op_q      <= req_i.op;
        end
    end

    always_comb begin
        sram_req_o.addr    = addr_q;
        sram_req_o.rd_en   = rd_en_q;
        sram_req_o.wr_en   = wr_en_q;
        sram_req_o.wr_data = wr_data_q;
        sram_req_o.wr_mask = wr_mask_q;
        sram_req_o.wr_size = {1'b0, op_q[1:0]};
        sram_req_o.rd_size = {1'b0, op_q[1:0]};
    end

    // move the addressed bytes down to lane 0.
    assign rd_shifted = rd_data_i >> {addr_q[2:0], 3'b000};

    always_comb begin
        case (op_q)
            rv_pkg::MEM_B:  rd_ext = {{(`XLEN-8){rd_shifted[7]}}, rd_shifted[7:0]};
            rv_pkg::MEM_H:  rd_ext = {{(`XLEN-16){rd_shifted[15]}}, rd_shifted[15:0]};
            rv_pkg::MEM_W:  rd_ext = {{(`XLEN-32){rd_shifted[31]}}, rd_shifted[31:0]};
            rv_pkg::MEM_BU: rd_ext = {{(`XLEN-8){1'b0}}, rd_shifted[7:0]};
            rv_pkg::MEM_HU: rd_ext = {{(`XLEN-16){1'b0}}, rd_shifted[15:0]};
            rv_pkg::MEM_WU: rd_ext = {{(`XLEN-32){1'b0}}, rd_shifted[31:0]};
            default:        rd_ext = rd_shifted;
        endcase
    end

    always_ff @(posedge clk) begin
        if ((state_q == ST_WAIT) && rd_valid_i) begin
            ls_res_o <= rd_ext;
        end
    end

    assign ls_not_ok_o = ((state_q == ST_IDLE) && mem_req) || (state_q == ST_WAIT);

endmodule

// File: src/csr_unit.sv
`timescale 1ns/10ps
`include "rv_settings.svh"

module csr_unit (
    input  logic             clk,
    input  logic             rst_n_i,
    input  logic             stall_n_i,
    input  logic [`XLEN-1:0] pc_i,
    input  rv_pkg::instr_u   instr_i,
    input  logic [`XLEN-1:0] wr_data_i,
    input  logic             trap_i,
    output logic [`XLEN-1:0] csr_data_o,
    output logic [`XLEN-1:0] mtvec_o,
    output logic [`XLEN-1:0] mepc_o
);

    // funct3[1:0], the immediate forms share them.
    localparam logic [1:0] CSR_RW = 2'b01;
    localparam logic [1:0] CSR_RS = 2'b10;
    localparam logic [1:0] CSR_RC = 2'b11;

    logic             is_csr;
    logic [11:0]      csr_addr;
    logic [1:0]       csr_op;
    logic [`XLEN-1:0] new_val;
    logic [`XLEN-1:0] mtvec_q;
    logic [`XLEN-1:0] mepc_q;
    logic [`XLEN-1:0] mcause_q;
    logic [`XLEN-1:0] mscratch_q;

    assign csr_addr = instr_i.csr.csr;
    assign csr_op   = instr_i.csr.funct3[1:0];
    assign is_csr   = (instr_i.csr.opcode == `OP_SYSTEM) && (csr_op != 2'b00);

    // old value, visible in the same cycle.
    always_comb begin
        case (csr_addr)
            `CSR_MTVEC:    csr_data_o = mtvec_q;
            `CSR_MEPC:     csr_data_o = mepc_q;
            `CSR_MCAUSE:   csr_data_o = mcause_q;
            `CSR_MSCRATCH: csr_data_o = mscratch_q;
            default:       csr_data_o = '0;
        endcase
    end

    always_comb begin
        case (csr_op)
            CSR_RW:  new_val = wr_data_i;
            CSR_RS:  new_val = csr_data_o | wr_data_i;
            CSR_RC:  new_val = csr_data_o & ~wr_data_i;
            default: new_val = csr_data_o;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mtvec_q    <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
            mscratch_q <= '0;
        end else if (stall_n_i) begin
            if (trap_i) begin
                // trap wins over any csr write in the same cycle.
                mepc_q   <= pc_i;
                mcause_q <= `MCAUSE_ECALL;
            end else if (is_csr) begin
                case (csr_addr)
                    `CSR_MTVEC:    mtvec_q    <= new_val;
                    `CSR_MEPC:     mepc_q     <= new_val;
                    `CSR_MCAUSE:   mcause_q   <= new_val;
                    `CSR_MSCRATCH: mscratch_q <= new_val;
                    default: begin
                    end
                endcase
            end
        end
    end

    assign mtvec_o = mtvec_q;
    assign mepc_o  = mepc_q;

endmodule

// File: src/ls_stage.sv
`timescale 1ns/10ps
`include "rv_settings.svh"

module ls_stage (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic [`XLEN-1:0]  pc_i,
    input  rv_pkg::instr_u    instr_i,
    input  logic [`XLEN-1:0]  alures_i,
    input  logic [`XLEN-1:0]  rs2_i,
    input  rv_pkg::instr_u    instr_last_i,
    input  logic [`XLEN-1:0]  wb_data_i,
    input  logic              trap_i,
    input  logic              stall_n_i,
    output logic [`XLEN-1:0]  ls_res_o,
    output logic              ls_not_ok_o,
    output logic [`XLEN-1:0]  csr_data_o,
    output logic [`XLEN-1:0]  mtvec_o,
    output logic [`XLEN-1:0]  mepc_o,
    output rv_pkg::sram_req_t sram_req_o,
    input  logic              rd_valid_i,
    input  logic              wr_ok_i,
    input  logic [`XLEN-1:0]  rd_data_i
);

    rv_pkg::ls_req_t ls_req;

    ls_ctr ls_ctr_u (
        .instr_i      (instr_i),
        .instr_last_i (instr_last_i),
        .rs2_i        (rs2_i),
        .wb_data_i    (wb_data_i),
        .req_o        (ls_req)
    );

    // alures carries the effective address for memory instructions.
    lsu lsu_u (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .stall_n_i   (stall_n_i),
        .addr_i      (alures_i),
        .req_i       (ls_req),
        .rd_valid_i  (rd_valid_i),
        .wr_ok_i     (wr_ok_i),
        .rd_data_i   (rd_data_i),
        .sram_req_o  (sram_req_o),
        .ls_res_o    (ls_res_o),
        .ls_not_ok_o (ls_not_ok_o)
    );

    csr_unit csr_u (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .stall_n_i  (stall_n_i),
        .pc_i       (pc_i),
        .instr_i    (instr_i),
        .wr_data_i  (alures_i),
        .trap_i     (trap_i),
        .csr_data_o (csr_data_o),
        .mtvec_o    (mtvec_o),
        .mepc_o     (mepc_o)
    );

endmodule

// File: bench/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o   = 1'b0;
        rst_n_o = 1'b0;
        repeat (2) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

    // 100 ns period.
    always #50 clk_o = ~clk_o;

endmodule

// File: bench/sram_model.sv
`timescale 1ns/10ps
`include "rv_settings.svh"

module sram_model (
    input  logic              clk,
    input  logic              rst_n_i,
    input  rv_pkg::sram_req_t req_i,
    output logic              rd_valid_o,
    output logic              wr_ok_o,
    output logic [`XLEN-1:0]  rd_data_o
);

    logic [`XLEN-1:0]   mem [64];
    logic               pending;
    logic               pend_wr;
    logic [5:0]         word;
    logic [`XLEN-1:0]   wdata;
    logic [`XLEN/8-1:0] wmask;
    int unsigned        delay;

    // every byte of a word holds its word address.
    initial begin
        void'($urandom(19));
        for (int i = 0; i < 64; i++) begin
            mem[i] = {8{8'(i)}};
        end
    end

    always @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_valid_o <= 1'b0;
            wr_ok_o    <= 1'b0;
            pending    <= 1'b0;
            delay      <= 0;
        end else begin
            rd_valid_o <= 1'b0;
            wr_ok_o    <= 1'b0;
            if (req_i.rd_en || req_i.wr_en) begin
                pending <= 1'b1;
                pend_wr <= req_i.wr_en;
                word    <= req_i.addr[8:3];
                wdata   <= req_i.wr_data;
                wmask   <= req_i.wr_mask;
                delay   <= $urandom_range(4, 1);
            end else if (pending) begin
                if (delay == 1) begin
                    pending <= 1'b0;
                    if (pend_wr) begin
                        for (int b = 0; b < 8; b++) begin
                            if (wmask[b]) begin
                                mem[word][b*8 +: 8] <= wdata[b*8 +: 8];
                            end
                        end
                        wr_ok_o <= 1'b1;
                    end else begin
                        rd_data_o  <= mem[word];
                        rd_valid_o <= 1'b1;
                    end
                end else begin
                    delay <= delay - 1;
                end
            end
        end
    end

endmodule

// File: bench/ls_stage_sva.sv
`timescale 1ns/10ps
`include "rv_settings.svh"

module ls_stage_sva (
    input logic              clk,
    input logic              rst_n_i,
    input rv_pkg::sram_req_t sram_req_o,
    input logic              rd_valid_i,
    input logic              wr_ok_i,
    input logic              ls_not_ok_o
);

    logic outstanding;
    int   fail_count;

    initial fail_count = 0;

    always @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            outstanding <= 1'b0;
        end else if (sram_req_o.rd_en || sram_req_o.wr_en) begin
            outstanding <= 1'b1;
        end else if (rd_valid_i || wr_ok_i) begin
            outstanding <= 1'b0;
        end
    end

    a_one_outstanding: assert property (@(posedge clk) disable iff (!rst_n_i)
        outstanding |-> !(sram_req_o.rd_en || sram_req_o.wr_en))
        else begin
            fail_count++;
            $error("new SRAM request while one is outstanding");
        end

    a_no_rd_wr: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(sram_req_o.rd_en && sram_req_o.wr_en))
        else begin
            fail_count++;
            $error("rd_en and wr_en high together");
        end

    a_release: assert property (@(posedge clk) disable iff (!rst_n_i)
        (rd_valid_i || wr_ok_i) |=> !ls_not_ok_o)
        else begin
            fail_count++;
            $error("ls_not_ok_o still high after the SRAM response");
        end

    a_reset_quiet: assert property (@(posedge clk)
        !rst_n_i |-> !(sram_req_o.rd_en || sram_req_o.wr_en || ls_not_ok_o))
        else begin
            fail_count++;
            $error("controls active under reset");
        end

endmodule

bind ls_stage ls_stage_sva i_sva (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .sram_req_o  (sram_req_o),
    .rd_valid_i  (rd_valid_i),
    .wr_ok_i     (wr_ok_i),
    .ls_not_ok_o (ls_not_ok_o)
);

// File: bench/ls_stage_tb.sv
`timescale 1ns/10ps
`include "rv_settings.svh"

module ls_stage_tb;

    localparam int MAX_VEC = 64;

    logic              clk;
    logic              rst_n;
    logic [`XLEN-1:0]  pc;
    logic [`XLEN-1:0]  alures;
    logic [`XLEN-1:0]  rs2;
    logic [`XLEN-1:0]  wb_data;
    rv_pkg::instr_u    instr;
    rv_pkg::instr_u    instr_last;
    logic              trap;
    logic              stall_n;
    logic [`XLEN-1:0]  ls_res;
    logic              ls_not_ok;
    logic [`XLEN-1:0]  csr_data;
    logic [`XLEN-1:0]  mtvec;
    logic [`XLEN-1:0]  mepc;
    rv_pkg::sram_req_t sram_req;
    logic              rd_valid;
    logic              wr_ok;
    logic [`XLEN-1:0]  rd_data;

    string             v_kind [MAX_VEC];
    string             v_name [MAX_VEC];
    logic [`XLEN-1:0]  v_pc [MAX_VEC];
    logic [31:0]       v_instr [MAX_VEC];
    logic [31:0]       v_last [MAX_VEC];
    logic [`XLEN-1:0]  v_alures [MAX_VEC];
    logic [`XLEN-1:0]  v_rs2 [MAX_VEC];
    logic [`XLEN-1:0]  v_wb [MAX_VEC];
    logic              v_trap [MAX_VEC];
    logic              v_stall_n [MAX_VEC];
    logic [`XLEN-1:0]  v_exp_a [MAX_VEC];
    logic [`XLEN-1:0]  v_exp_b [MAX_VEC];
    logic [`XLEN-1:0]  v_exp_c [MAX_VEC];

    int n_vec;
    int errors;
    int failed_tests;
    int cycles;
    int cycle_limit;
    bit test_ok;

    tb_clock_gen i_clk (.clk_o(clk), .rst_n_o(rst_n));

    ls_stage i_dut (
        .clk          (clk),
        .rst_n_i      (rst_n),
        .pc_i         (pc),
        .instr_i      (instr),
        .alures_i     (alures),
        .rs2_i        (rs2),
        .instr_last_i (instr_last),
        .wb_data_i    (wb_data),
        .trap_i       (trap),
        .stall_n_i    (stall_n),
        .ls_res_o     (ls_res),
        .ls_not_ok_o  (ls_not_ok),
        .csr_data_o   (csr_data),
        .mtvec_o      (mtvec),
        .mepc_o       (mepc),
        .sram_req_o   (sram_req),
        .rd_valid_i   (rd_valid),
        .wr_ok_i      (wr_ok),
        .rd_data_i    (rd_data)
    );

    sram_model i_sram (
        .clk        (clk),
        .rst_n_i    (rst_n),
        .req_i      (sram_req),
        .rd_valid_o (rd_valid),
        .wr_ok_o    (wr_ok),
        .rd_data_o  (rd_data)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("timeout: the run hung after %0d cycles", cycles);
            $display("Test failed");
            $finish;
        end
    end

    task automatic compare_value(input string sig, input logic [`XLEN-1:0] exp,
                                 input logic [`XLEN-1:0] act);
        assert (act === exp) else begin
            $display("error: time %0t %s expected %h got %h", $time, sig, exp, act);
            errors++;
            test_ok = 0;
        end
    endtask

    // log2 of the bytes moved, per the load/store width in funct3.
    function automatic logic [2:0] access_size(input logic [31:0] word);
        case (word[14:12])
            3'b000, 3'b100: access_size = 3'd0;
            3'b001, 3'b101: access_size = 3'd1;
            3'b010, 3'b110: access_size = 3'd2;
            default:        access_size = 3'd3;
        endcase
    endfunction

    task automatic load_vectors();
        int    fd;
        int    cnt;
        int    tr;
        int    st;
        string line;
        fd = $fopen("bench/ls_stage_golden.txt", "r");
        assert (fd != 0) else begin
            $display("could not open the golden vector file");
            errors++;
        end
        n_vec = 0;
        while (fd != 0 && !$feof(fd) && n_vec < MAX_VEC) begin
            cnt = $fgets(line, fd);
            if (cnt > 1 && line.getc(0) != 8'h23) begin
                cnt = $sscanf(line, "%s %s %h %h %h %h %h %h %h %h %h %h %h",
                              v_kind[n_vec], v_name[n_vec], v_pc[n_vec], v_instr[n_vec],
                              v_last[n_vec], v_alures[n_vec], v_rs2[n_vec], v_wb[n_vec],
                              tr, st, v_exp_a[n_vec], v_exp_b[n_vec], v_exp_c[n_vec]);
                if (cnt == 13) begin
                    v_trap[n_vec]    = tr[0];
                    v_stall_n[n_vec] = st[0];
                    n_vec++;
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
    endtask

    task automatic apply_inputs(input int i);
        pc         = v_pc[i];
        instr      = v_instr[i];
        instr_last = v_last[i];
        alures     = v_alures[i];
        rs2        = v_rs2[i];
        wb_data    = v_wb[i];
        trap       = v_trap[i];
        stall_n    = v_stall_n[i];
    endtask

    // memory access, waits for the stall to drop.
    task automatic run_mem_vector(input int i);
        bit                 seen_wr;
        bit                 seen_rd;
        logic [`XLEN-1:0]   lanes;
        logic [`XLEN/8-1:0] mask;
        logic [2:0]         req_size;
        seen_wr  = 0;
        seen_rd  = 0;
        lanes    = '0;
        mask     = '0;
        req_size = '0;
        apply_inputs(i);
        do begin
            @(negedge clk);
            if (sram_req.wr_en) begin
                seen_wr  = 1;
                lanes    = sram_req.wr_data;
                mask     = sram_req.wr_mask;
                req_size = sram_req.wr_size;
            end
            if (sram_req.rd_en) begin
                seen_rd  = 1;
                req_size = sram_req.rd_size;
            end
        end while (ls_not_ok);
        if (v_kind[i] == "S") begin
            assert (seen_wr) else begin
                $display("store request never reached the SRAM port");
                errors++;
                test_ok = 0;
            end
            compare_value("wr_data", v_exp_a[i], lanes);
            compare_value("wr_mask", v_exp_b[i], {56'd0, mask});
            compare_value("wr_size", {61'd0, access_size(v_instr[i])}, {61'd0, req_size});
        end else begin
            assert (seen_rd) else begin
                $display("load request never reached the SRAM port");
                errors++;
                test_ok = 0;
            end
            compare_value("ls_res_o", v_exp_a[i], ls_res);
            compare_value("rd_size", {61'd0, access_size(v_instr[i])}, {61'd0, req_size});
        end
    endtask

    task automatic run_csr_vector(input int i);
        apply_inputs(i);
        #25;
        compare_value("csr_data_o", v_exp_a[i], csr_data);
        @(negedge clk);
        compare_value("mtvec_o", v_exp_b[i], mtvec);
        compare_value("mepc_o", v_exp_c[i], mepc);
    endtask

    initial begin
        pc           = '0;
        instr        = '0;
        instr_last   = '0;
        alures       = '0;
        rs2          = '0;
        wb_data      = '0;
        trap         = 1'b0;
        stall_n      = 1'b1;
        errors       = 0;
        failed_tests = 0;
        cycles       = 0;
        cycle_limit  = 0;

        load_vectors();
        cycle_limit = n_vec * 7 + 20;

        // quiet outputs while reset is held.
        #10;
        test_ok = 1;
        compare_value("sram rd_en", '0, {63'd0, sram_req.rd_en});
        compare_value("sram wr_en", '0, {63'd0, sram_req.wr_en});
        compare_value("ls_not_ok_o", '0, {63'd0, ls_not_ok});
        wait (rst_n);
        @(negedge clk);
        compare_value("csr_data_o", '0, csr_data);
        compare_value("mtvec_o", '0, mtvec);
        compare_value("mepc_o", '0, mepc);
        $display("reset_state %s", test_ok ? "ok" : "mismatch");
        if (!test_ok) begin
            failed_tests++;
        end

        for (int i = 0; i < n_vec; i++) begin
            test_ok = 1;
            if (v_kind[i] == "C") begin
                run_csr_vector(i);
            end else begin
                run_mem_vector(i);
            end
            $display("%s %s", v_name[i], test_ok ? "ok" : "mismatch");
            if (!test_ok) begin
                failed_tests++;
            end
        end

        errors = errors + i_dut.i_sva.fail_count;
        $display("tests %0d failed %0d errors %0d", n_vec + 1, failed_tests, errors);
        if (errors == 0 && n_vec > 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+src
src/rv_pkg.sv
src/ls_ctr.sv
src/lsu.sv
src/csr_unit.sv
src/ls_stage.sv
bench/tb_clock_gen.sv
bench/sram_model.sv
bench/ls_stage_sva.sv
bench/ls_stage_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the ls_stage testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f build.f \
    --top-module ls_stage_tb \
    -o ls_stage_sim

./obj_dir/ls_stage_sim +verilator+error+limit+1000 > sim.log
cat sim.log

grep -q "Test passed" sim.log

// File: bench/ls_stage_golden.txt
# kind name pc instr instr_last alures rs2 wb_data trap stall_n exp_a exp_b exp_c (hex)
# L exp_a=ls_res_o; S exp_a=lanes exp_b=mask; C exp_a=old csr, exp_b/c=mtvec/mepc after
L lb_off3 0 00008283 000001b3 43 0 0 0 1 8 0 0
L lbu_off7 0 0000c283 000001b3 47 0 0 0 1 8 0 0
L lh_off6 0 00009283 000001b3 46 0 0 0 1 808 0 0
L lhu_off2 0 0000d283 000001b3 42 0 0 0 1 808 0 0
L lw_off4 0 0000a283 000001b3 44 0 0 0 1 8080808 0 0
L lwu_off0 0 0000e283 000001b3 40 0 0 0 1 8080808 0 0
L ld_off0 0 0000b283 000001b3 40 0 0 0 1 0808080808080808 0 0
S sb_off1 0 00708023 000001b3 81 f1 0 0 1 f100 2 0
L lb_merged 0 00008283 000001b3 81 0 0 0 1 fffffffffffffff1 0 0
S sh_off4 0 00709023 000001b3 94 a5b6 0 0 1 a5b600000000 30 0
L lhu_merged 0 0000d283 000001b3 94 0 0 0 1 a5b6 0 0
S sw_off0 0 0070a023 000001b3 a0 1122334487654321 0 0 1 1122334487654321 f 0
L lw_merged 0 0000a283 000001b3 a0 0 0 0 1 ffffffff87654321 0 0
L ld_merged 0 0000b283 000001b3 a0 0 0 0 1 1414141487654321 0 0
S sd_fwd 0 0070b023 000003b3 b0 1111111111111111 deadbeefcafef00d 0 1 deadbeefcafef00d ff 0
S sd_rd_x0 0 0000b023 00000033 b8 0123456789abcdef ffffffffffffffff 0 1 0123456789abcdef ff 0
S sd_last_st 0 0070b023 0070b3a3 c0 5555555555555555 aaaaaaaaaaaaaaaa 0 1 5555555555555555 ff 0
C rw_mtvec 1000 305110f3 0 80001000 0 0 0 1 0 80001000 0
C rs_mtvec 1004 305120f3 0 f 0 0 0 1 80001000 8000100f 0
C rc_mtvec 1008 305130f3 0 3 0 0 0 1 8000100f 8000100c 0
C rw_mepc 100c 341110f3 0 2000 0 0 0 1 0 8000100c 2000
C rs_mepc 1010 341120f3 0 11 0 0 0 1 2000 8000100c 2011
C rc_mepc 1014 341130f3 0 2001 0 0 0 1 2011 8000100c 10
C rw_mscratch 1018 340110f3 0 cafe 0 0 0 1 0 8000100c 10
C rs_mscratch 101c 340120f3 0 f0000 0 0 0 1 cafe 8000100c 10
C rc_mscratch 1020 340130f3 0 fe 0 0 0 1 fcafe 8000100c 10
C rd_mscratch 1024 340120f3 0 0 0 0 0 1 fca00 8000100c 10
C rw_mcause 1028 342110f3 0 5 0 0 0 1 0 8000100c 10
C rs_mcause 102c 342120f3 0 8 0 0 0 1 5 8000100c 10
C rc_mcause 1030 342130f3 0 1 0 0 0 1 d 8000100c 10
C trap 4000 305110f3 0 9999 0 0 1 1 8000100c 8000100c 4000
C rd_mcause 1034 342120f3 0 0 0 0 0 1 b 8000100c 4000
C stall_trap 5000 341110f3 0 7777 0 0 1 0 4000 8000100c 4000
C stall_write 1038 305110f3 0 1234 0 0 0 0 8000100c 8000100c 4000
C rd_mtvec 103c 305120f3 0 0 0 0 0 1 8000100c 8000100c 4000
